//--- src/hmulDefines.svh
`ifndef HMUL_DEFINES_SVH
`define HMUL_DEFINES_SVH

// binary16 field layout
`define HALF_EXP_W 5 // Exponent bits
`define HALF_MAN_W 10 // Stored mantissa bits, hidden one not counted

// Exponent bias for binary16
`define HALF_BIAS 15

// Canonical quiet NaN
// Sign clear, exponent all ones, top mantissa bit set
`define HALF_QNAN 16'h7E00

// Enabled edges from operand sample to result
// Operand reg, stage reg, result reg
`define HMUL_LATENCY 2

`endif

//--- src/hmulPkg.sv
package hmulPkg;

	`include "hmulDefines.svh"

	// One binary16 value, msb first
	typedef struct packed {
		logic sign; // 1 means negative
		logic [`HALF_EXP_W-1:0] exp; // Biased exponent
		logic [`HALF_MAN_W-1:0] man; // Fraction without hidden one
	} halfFloat_t;

	// Operand classes
	// Subnormal encodings are folded into clsZero
	typedef enum logic [2:0] {
		clsZero = 3'd0,
		clsNormal = 3'd1,
		clsInf = 3'd2,
		clsQnan = 3'd3,
		clsSnan = 3'd4
	} fpClass_t;

	// Exception flags, sticky only for one result
	typedef struct packed {
		logic invalid; // Inf times zero or signaling NaN in
		logic overflow; // Result too large, went to inf
		logic underflow; // Result too small, flushed to zero
		logic inexact; // Some bits lost
	} fpFlags_t;

	// Prep to round payload, 36 bits
	typedef struct packed {
		logic sign; // Product sign
		logic signed [`HALF_EXP_W+1:0] expSum; // ea + eb - bias, before normalizing
		logic [2*`HALF_MAN_W+1:0] manProd; // 11 x 11 significand product
		fpClass_t classA;
		fpClass_t classB;
	} mulStage_t;

	// Final product plus its flags, 20 bits
	typedef struct packed {
		halfFloat_t value;
		fpFlags_t flags;
	} mulResult_t;

endpackage

//--- src/fpMulPrep.sv
`timescale 1ns/1ns

`include "hmulDefines.svh"

// First half of the multiply
// Classifies operands, xors signs, adds exponents and multiplies significands
module fpMulPrep (
	input hmulPkg::halfFloat_t a,
	input hmulPkg::halfFloat_t b,
	output hmulPkg::mulStage_t stage
);

	import hmulPkg::*;

	localparam int SigW = `HALF_MAN_W + 1; // Significand width with hidden one
	localparam int ExpSumW = `HALF_EXP_W + 2; // Room for sign and carry

	// Class of one operand from its fields
	function automatic fpClass_t classify(input halfFloat_t v);
		fpClass_t cls;
		if (v.exp == '0) begin
			cls = clsZero; // Zero and subnormal alike
		end else if (v.exp == '1) begin
			if (v.man == '0)
				cls = clsInf;
			else if (v.man[`HALF_MAN_W-1])
				cls = clsQnan; // Quiet bit set
			else
				cls = clsSnan;
		end else begin
			cls = clsNormal;
		end
		return cls;
	endfunction

	logic [SigW-1:0] sigA; // Significands with hidden bit
	logic [SigW-1:0] sigB;
	logic [ExpSumW-1:0] expA; // Zero extended exponents
	logic [ExpSumW-1:0] expB;

	// Hidden one only for nonzero exponent
	// Zero and subnormal give a zero significand
	assign sigA = (a.exp != '0) ? {1'b1, a.man} : '0;
	assign sigB = (b.exp != '0) ? {1'b1, b.man} : '0;

	assign expA = {2'b00, a.exp};
	assign expB = {2'b00, b.exp};

	always_comb begin
		stage.sign = a.sign ^ b.sign; // Equal signs give positive
		stage.expSum = expA + expB - ExpSumW'(`HALF_BIAS); // Range -13..45 for normal inputs
		stage.manProd = sigA * sigB; // Full 22 bit product in [1,4) for normals
		stage.classA = classify(a);
		stage.classB = classify(b);
	end

endmodule

//--- src/fpMulRound.sv
`timescale 1ns/1ns

`include "hmulDefines.svh"

// Second half of the multiply
// Normalize, round to nearest even, range limits and special values
module fpMulRound (
	input hmulPkg::mulStage_t stage,
	output hmulPkg::mulResult_t result
);

	import hmulPkg::*;

	localparam int ProdW = 2 * `HALF_MAN_W + 2; // 22
	localparam int ExpW = `HALF_EXP_W + 3; // Signed working exponent
	localparam int MaxExp = (1 << `HALF_EXP_W) - 1; // 31, reserved for inf/NaN

	logic [ProdW-1:0] norm; // Product with leading one at the top
	logic guardBit;
	logic roundBit;
	logic stickyBit;
	logic roundUp;
	logic [`HALF_MAN_W+1:0] manRnd; // Carry, hidden one, fraction
	logic signed [ExpW-1:0] expNorm; // After the first shift
	logic signed [ExpW-1:0] expFin; // After rounding carry
	logic aNan, bNan, aInf, bInf, aZero, bZero;
	logic anySnan;

	// Shift left by one when the product is below 2, top bit is then the hidden one
	assign norm = stage.manProd[ProdW-1] ? stage.manProd : {stage.manProd[ProdW-2:0], 1'b0};

	// Bump exponent when product was in [2,4)
	assign expNorm = {stage.expSum[ExpW-2], stage.expSum} + ExpW'(stage.manProd[ProdW-1]);

	assign guardBit = norm[ProdW-`HALF_MAN_W-2]; // First bit below the lsb
	assign roundBit = norm[ProdW-`HALF_MAN_W-3];
	assign stickyBit = |norm[ProdW-`HALF_MAN_W-4:0];

	// Nearest even, tie goes up only on an odd lsb
	assign roundUp = guardBit & (roundBit | stickyBit | norm[ProdW-`HALF_MAN_W-1]);

	assign manRnd = {1'b0, norm[ProdW-1:ProdW-`HALF_MAN_W-1]} + (`HALF_MAN_W+2)'(roundUp);

	// Carry out of rounding means 1.111..1 became 10.000..0
	// Fraction bits are already zero then, only the exponent moves
	assign expFin = expNorm + ExpW'(manRnd[`HALF_MAN_W+1]);

	// Operand class decode
	assign aNan = (stage.classA == clsQnan) || (stage.classA == clsSnan);
	assign bNan = (stage.classB == clsQnan) || (stage.classB == clsSnan);
	assign aInf = stage.classA == clsInf;
	assign bInf = stage.classB == clsInf;
	assign aZero = stage.classA == clsZero;
	assign bZero = stage.classB == clsZero;
	assign anySnan = (stage.classA == clsSnan) || (stage.classB == clsSnan);

	always_comb begin
		result = '0;
		result.value.sign = stage.sign; // Default for every signed result
		if (aNan || bNan || (aInf && bZero) || (aZero && bInf)) begin
			// Canonical NaN, sign from the pattern
			result.value = `HALF_QNAN;
			result.flags.invalid = anySnan | (aInf & bZero) | (aZero & bInf);
		end else if (aInf || bInf) begin
			result.value.exp = '1; // Signed inf, exact
		end else if (aZero || bZero) begin
			// Signed zero, exp and man stay clear
		end else if (expFin >= ExpW'(MaxExp)) begin
			result.value.exp = '1; // Overflow to inf
			result.flags.overflow = 1'b1;
			result.flags.inexact = 1'b1;
		end else if (expFin <= 0) begin
			// Flush, subnormal results are not produced
			result.flags.underflow = 1'b1;
			result.flags.inexact = 1'b1;
		end else begin
			result.value.exp = expFin[`HALF_EXP_W-1:0];
			result.value.man = manRnd[`HALF_MAN_W-1:0]; // Zero after a rounding carry
			result.flags.inexact = guardBit | roundBit | stickyBit;
		end
	end

endmodule

//--- src/hmulUnit.sv
`timescale 1ns/1ns

// Two stage binary16 multiplier
// ce freezes all three registers together, output holds while low
module hmulUnit (
	input logic clk,
	input logic rst,
	input logic ce,
	input hmulPkg::halfFloat_t din0,
	input hmulPkg::halfFloat_t din1,
	output hmulPkg::halfFloat_t dout,
	output hmulPkg::fpFlags_t flags
);

	import hmulPkg::*;

	halfFloat_t opA; // Operand register
	halfFloat_t opB;
	mulStage_t prepStage; // Comb out of prep
	mulStage_t stageQ; // Stage register
	mulResult_t roundRes; // Comb out of round
	mulResult_t resQ; // Result register

	// Operand capture
	always_ff @(posedge clk) begin
		if (rst) begin
			opA <= '0;
			opB <= '0;
		end else if (ce) begin
			opA <= din0;
			opB <= din1;
		end
	end

	// Classify, add exponents, multiply significands
	fpMulPrep u_prep (
		.a(opA),
		.b(opB),
		.stage(prepStage)
	);

	// Middle register between the two halves
	always_ff @(posedge clk) begin
		if (rst)
			stageQ <= '0; // Class zero, rounds to +0
		else if (ce)
			stageQ <= prepStage;
	end

	// Normalize, round, range and specials
	fpMulRound u_round (
		.stage(stageQ),
		.result(roundRes)
	);

	// Result register
	always_ff @(posedge clk) begin
		if (rst)
			resQ <= '0;
		else if (ce)
			resQ <= roundRes;
	end

	// Outputs straight from the register
	assign dout = resQ.value;
	assign flags = resQ.flags;

endmodule

//--- testbench/hmulModel.sv
package hmulModel;

	// Expected product and flags, flags are invalid, overflow, underflow, inexact
	typedef struct packed {
		logic [15:0] value;
		logic [3:0] flags;
	} mulExpect_t;

	localparam int Bias = 15;
	localparam logic [15:0] QuietNan = 16'h7E00;

	// Field tests on raw binary16 bits
	function automatic bit isZero(input logic [15:0] v);
		return v[14:10] == 5'd0; // Subnormals count as zero
	endfunction

	function automatic bit isInf(input logic [15:0] v);
		return (v[14:10] == 5'h1F) && (v[9:0] == 10'd0);
	endfunction

	function automatic bit isNan(input logic [15:0] v);
		return (v[14:10] == 5'h1F) && (v[9:0] != 10'd0);
	endfunction

	function automatic bit isSnan(input logic [15:0] v);
		return isNan(v) && !v[9]; // Quiet bit clear
	endfunction

	// Reference multiply on plain integers
	function automatic mulExpect_t mulModel(input logic [15:0] a, input logic [15:0] b);
		mulExpect_t r;
		logic sgn;
		logic badInf; // Inf times zero
		int e;
		int shift;
		longint p;
		longint mant;
		longint rem;
		longint half;
		r = '0;
		sgn = a[15] ^ b[15];
		badInf = (isInf(a) && isZero(b)) || (isZero(a) && isInf(b));
		if (isNan(a) || isNan(b) || badInf) begin
			r.value = QuietNan;
			r.flags[3] = isSnan(a) || isSnan(b) || badInf;
			return r;
		end
		if (isInf(a) || isInf(b)) begin
			r.value = {sgn, 5'h1F, 10'h000}; // Exact signed inf
			return r;
		end
		if (isZero(a) || isZero(b)) begin
			r.value = {sgn, 15'h0000};
			return r;
		end
		p = longint'({1'b1, a[9:0]}) * longint'({1'b1, b[9:0]});
		e = int'(a[14:10]) + int'(b[14:10]) - Bias;
		// Keep 11 significant bits, product is in [1,4)
		if (p >= (longint'(1) << 21)) begin
			shift = 11;
			e++;
		end else begin
			shift = 10;
		end
		mant = p >> shift;
		rem = p - (mant << shift); // Dropped part
		half = longint'(1) << (shift - 1);
		if ((rem > half) || ((rem == half) && ((mant % 2) == 1)))
			mant++; // Nearest, ties to even
		if (mant == 2048) begin
			mant = 1024; // Rounded up to the next binade
			e++;
		end
		if (e >= 31) begin
			r.value = {sgn, 5'h1F, 10'h000};
			r.flags = 4'b0101;
		end else if (e <= 0) begin
			r.value = {sgn, 15'h0000}; // Flushed
			r.flags = 4'b0011;
		end else begin
			r.value = {sgn, 5'(e), 10'(mant - 1024)};
			r.flags[0] = (rem != 0);
		end
		return r;
	endfunction

endpackage

//--- testbench/hmulTb.sv
`timescale 1ns/1ns

`include "hmulDefines.svh"

module hmulTb;

	import hmulPkg::*;
	import hmulModel::*;

	localparam int DrainLimit = 20; // Cycles allowed to empty the pipe

	logic clk;
	logic rst;
	logic ce;
	halfFloat_t din0;
	halfFloat_t din1;
	halfFloat_t dout;
	fpFlags_t flags;

	// Scoreboard of pairs in flight
	mulExpect_t expQ[$];
	int edgeQ[$]; // Enabled edge that sampled the pair
	string nameQ[$];
	int enEdges; // Enabled edges since reset
	int realPending; // Entries still owed to a test
	logic [19:0] lastOut; // dout and flags one cycle back

	hmulUnit u_dut (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.din0(din0),
		.din1(din1),
		.dout(dout),
		.flags(flags)
	);

	always #2 clk = ~clk; // 4 ns period

	task automatic failRun(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic pushExpect(input mulExpect_t want, input int edgeNo, input string name);
		expQ.push_back(want);
		edgeQ.push_back(edgeNo);
		nameQ.push_back(name);
		if (name != "flush")
			realPending++;
	endtask

	// Check outputs just after the edge and then drive the next inputs
	task automatic stepCycle(input logic nextCe, input logic [15:0] a, input logic [15:0] b,
		input string name);
		logic enabled;
		logic [19:0] now;
		mulExpect_t want;
		string wantName;
		enabled = ce;
		@(posedge clk);
		#1;
		now = {dout, flags};
		if (enabled) begin
			enEdges++;
			// Oldest pair is due two enabled edges after it was sampled
			if ((edgeQ.size() > 0) && (enEdges - edgeQ[0] == `HMUL_LATENCY)) begin
				want = expQ.pop_front();
				edgeQ.delete(0);
				wantName = nameQ.pop_front();
				if (wantName != "flush")
					realPending--;
				assert (now == {want.value, want.flags})
					else failRun($sformatf("ERR %s: expected %h/%b actual %h/%b", wantName,
						want.value, want.flags, dout, flags));
			end
		end else begin
			// Output must not move while the pipe is frozen
			assert (now == lastOut)
				else failRun($sformatf("ERR %s hold: expected %h actual %h", name, lastOut, now));
		end
		lastOut = now;
		ce = nextCe;
		din0 = a;
		din1 = b;
		if (nextCe)
			pushExpect(mulModel(a, b), enEdges + 1, name);
	endtask

	// Keep ce high until every real result is out
	task automatic drainPipe();
		int n;
		n = 0;
		while ((realPending > 0) && (n < DrainLimit)) begin
			stepCycle(1'b1, 16'h0000, 16'h0000, "flush");
			n++;
		end
		assert (realPending == 0)
			else failRun("Timeout, pipeline results did not arrive within the drain limit");
	endtask

	// Cross check the model with a hand worked product before sending it
	task automatic sendKnown(input logic [15:0] a, input logic [15:0] b,
		input logic [15:0] wantV, input logic [3:0] wantF, input string name);
		mulExpect_t m;
		m = mulModel(a, b);
		assert ((m.value == wantV) && (m.flags == wantF))
			else failRun($sformatf("ERR %s model: expected %h/%b actual %h/%b", name,
				wantV, wantF, m.value, m.flags));
		stepCycle(1'b1, a, b, name);
	endtask

	function automatic logic [15:0] randNormal();
		logic [4:0] e;
		logic [9:0] m;
		e = 5'($urandom_range(1, 30)); // No zero, subnormal, inf or NaN
		m = 10'($urandom);
		return {1'($urandom), e, m};
	endfunction

	task automatic resetTest();
		rst = 1'b1;
		ce = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		enEdges = 0;
		// Stage and operand regs hold zeros that come out first
		pushExpect('0, -1, "reset");
		pushExpect('0, 0, "reset");
		assert ({dout, flags} == 20'h0)
			else failRun($sformatf("ERR reset: expected %h actual %h", 20'h0, {dout, flags}));
		lastOut = {dout, flags};
		stepCycle(1'b0, 16'h3E00, 16'h4000, "reset"); // Pair ignored while ce is low
		stepCycle(1'b1, 16'h3E00, 16'h4000, "reset");
		stepCycle(1'b1, 16'h3E00, 16'h4000, "reset");
		drainPipe();
	endtask

	task automatic exactTest();
		sendKnown(16'h3E00, 16'h4000, 16'h4200, 4'b0000, "exact"); // 1.5 * 2
		sendKnown(16'hB800, 16'h4400, 16'hC000, 4'b0000, "exact"); // -0.5 * 4
		sendKnown(16'h3C00, 16'h3C00, 16'h3C00, 4'b0000, "exact");
		sendKnown(16'hBE00, 16'hC000, 16'h4200, 4'b0000, "exact"); // Neg times neg
		sendKnown(16'h3E00, 16'hC000, 16'hC200, 4'b0000, "exact");
		sendKnown(16'hBC00, 16'h3C00, 16'hBC00, 4'b0000, "exact");
		drainPipe();
	endtask

	task automatic specialTest();
		sendKnown(16'h7E00, 16'h3C00, 16'h7E00, 4'b0000, "special"); // qNaN
		sendKnown(16'hFE01, 16'h4000, 16'h7E00, 4'b0000, "special"); // qNaN with payload
		sendKnown(16'h7C01, 16'h3C00, 16'h7E00, 4'b1000, "special"); // sNaN
		sendKnown(16'h3C00, 16'hFD00, 16'h7E00, 4'b1000, "special");
		sendKnown(16'h7C00, 16'hC000, 16'hFC00, 4'b0000, "special"); // Inf times -2
		sendKnown(16'hFC00, 16'hFC00, 16'h7C00, 4'b0000, "special");
		sendKnown(16'h7C00, 16'h0000, 16'h7E00, 4'b1000, "special"); // Inf times zero
		sendKnown(16'h8000, 16'hFC00, 16'h7E00, 4'b1000, "special");
		sendKnown(16'h0001, 16'h4000, 16'h0000, 4'b0000, "special"); // Subnormal as zero
		sendKnown(16'h83FF, 16'h3C00, 16'h8000, 4'b0000, "special");
		sendKnown(16'h0200, 16'h7C00, 16'h7E00, 4'b1000, "special");
		drainPipe();
	endtask

	task automatic rangeTest();
		sendKnown(16'h7BFF, 16'h4000, 16'h7C00, 4'b0101, "range"); // Max times 2
		sendKnown(16'hDC00, 16'h5C00, 16'hFC00, 4'b0101, "range"); // -256 * 256
		sendKnown(16'h0400, 16'h3800, 16'h0000, 4'b0011, "range"); // Min normal halved
		sendKnown(16'h8400, 16'h3800, 16'h8000, 4'b0011, "range");
		sendKnown(16'h3E00, 16'h3C01, 16'h3E02, 4'b0001, "range"); // Tie with odd lsb goes up
		sendKnown(16'h3E00, 16'h3C03, 16'h3E04, 4'b0001, "range"); // Tie with even lsb stays
		sendKnown(16'h3E00, 16'h3D55, 16'h4000, 4'b0001, "range"); // Carry out to 2.0
		drainPipe();
	endtask

	task automatic streamTest();
		for (int i = 0; i < 300; i++)
			stepCycle(1'b1, randNormal(), randNormal(), "stream");
		drainPipe();
	endtask

	// Operands on ce low cycles must be ignored
	task automatic stallTest();
		logic c;
		for (int i = 0; i < 200; i++) begin
			c = ($urandom_range(0, 2) != 0);
			stepCycle(c, randNormal(), randNormal(), "stall");
		end
		drainPipe();
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		ce = 1'b0;
		din0 = '0;
		din1 = '0;
		enEdges = 0;
		realPending = 0;
		lastOut = '0;
		void'($urandom(50023));
		resetTest();
		exactTest();
		specialTest();
		rangeTest();
		streamTest();
		stallTest();
		$display("test passed");
		$finish;
	end

endmodule

//--- hmulUnit.f
+incdir+src
src/hmulPkg.sv
src/fpMulPrep.sv
src/fpMulRound.sv
src/hmulUnit.sv
testbench/hmulModel.sv
testbench/hmulTb.sv

//--- Bender.yml
package:
  name: hmulUnit

sources:
  - include_dirs:
      - src
    files:
      - src/hmulPkg.sv
      - src/fpMulPrep.sv
      - src/fpMulRound.sv
      - src/hmulUnit.sv
  - target: test
    include_dirs:
      - src
    files:
      - testbench/hmulModel.sv
      - testbench/hmulTb.sv
